/* src.f */
source/game_pkg.sv
source/draw_pkg.sv
source/frame_sequencer.sv
source/ball_motion.sv
source/brick_cell.sv
source/hit_resolver.sv
source/paddle.sv
source/plot_engine.sv
source/brickbreaker.sv
testbench/tb_clock.sv
testbench/brickbreaker_props.sv
testbench/brickbreaker_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module brickbreaker_tb -o sim_brickbreaker
./obj_dir/sim_brickbreaker > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

/* testbench/brickbreaker_tb.sv */
`timescale 1ns/1ns

module brickbreaker_tb;
	import game_pkg::*;
	import draw_pkg::*;

	typedef struct packed {
		logic       level;
		logic       left;
		logic       right;
		logic       rnd;      // Left and right from the generator each frame
		logic [9:0] frames;   // Upper bound, a finished game ends the row early
		logic [1:0] ends;     // 0 running, 1 win, 2 loss
	} row_t;

	row_t rows [5] = '{
		'{1'b0, 1'b0, 1'b0, 1'b0, 10'd120, 2'd0},   // Side wall, top wall, first brick
		'{1'b0, 1'b0, 1'b0, 1'b1, 10'd40, 2'd0},
		'{1'b0, 1'b0, 1'b1, 1'b0, 10'd220, 2'd2},   // Paddle parked right, ball drops past
		'{1'b1, 1'b1, 1'b0, 1'b0, 10'd23, 2'd0},    // Slide under the first drop
		'{1'b1, 1'b0, 1'b0, 1'b0, 10'd300, 2'd1}
	};

	logic clk;
	logic resetn;
	logic start;
	logic left;
	logic right;
	logic level;
	coord_t plot_x;
	coord_t plot_y;
	colour_t plot_colour;
	logic plot_en;
	logic frame_done;
	coord_t ball_x;
	coord_t ball_y;
	logic [N_BRICKS-1:0] brick_alive;
	logic win;
	logic loss;

	// Reference model state
	int m_x;
	int m_y;
	int m_px;
	bit m_dx;   // 1 moves right
	bit m_dy;   // 1 moves down
	int m_health [N_BRICKS];
	bit m_win;
	bit m_loss;
	bit m_hit;
	int m_hit_idx;
	int old_x;
	int old_y;
	logic [31:0] rng_state = 32'd54;
	logic [18:0] got_q [$];   // {x, y, colour}
	logic [18:0] exp_q [$];

	tb_clock u_clock (.clk(clk));

	brickbreaker dut (.*);

	bind brickbreaker brickbreaker_props u_props (
		.clk(clk), .resetn(resetn), .plot_en(plot_en), .plot_x(plot_x), .plot_y(plot_y),
		.frame_done(frame_done), .win(win), .loss(loss)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic int total_frames();
		int sum;
		sum = 0;
		foreach (rows[r])
			sum += int'(rows[r].frames);
		return sum;
	endfunction

	function automatic logic [N_BRICKS-1:0] model_alive();
		logic [N_BRICKS-1:0] a;
		for (int i = 0; i < N_BRICKS; i++)
			a[i] = (m_health[i] != 0);
		return a;
	endfunction

	task automatic stop_on_failure();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic expect_equal(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("FAILED time %0t signal %s got %0d expected %0d", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic model_reset(input logic lv);
		m_x = BALL_X0;
		m_y = BALL_Y0;
		m_dx = 1'b1;
		m_dy = 1'b0;
		m_px = PADDLE_START;
		m_win = 1'b0;
		m_loss = 1'b0;
		for (int i = 0; i < N_BRICKS; i++)
			m_health[i] = lv ? int'(LEVEL1_HEALTH[i]) : int'(LEVEL0_HEALTH[i]);
	endtask

	// One game step, ball sees the paddle from before this frame
	task automatic model_step(input logic l, input logic r);
		bit ndx;
		bit ndy;
		int bx;
		int by;
		old_x = m_x;
		old_y = m_y;
		m_hit = 1'b0;
		if (!m_loss) begin
			ndx = m_dx;
			if (m_dx && m_x == SCREEN_W - BALL_SIZE)
				ndx = 1'b0;
			else if (!m_dx && m_x == 0)
				ndx = 1'b1;
			ndy = m_dy;
			if (!m_dy && m_y == 0)
				ndy = 1'b1;
			else if (m_dy && m_y + BALL_SIZE == PADDLE_Y && m_x + BALL_SIZE - 1 >= m_px &&
					m_x <= m_px + PADDLE_W - 1)
				ndy = 1'b0;
			if (ndy && m_y >= SCREEN_H - BALL_SIZE) begin
				m_loss = 1'b1;   // Would drop below the frame
			end else begin
				m_x = ndx ? m_x + 1 : m_x - 1;
				m_y = ndy ? m_y + 1 : m_y - 1;
				m_dx = ndx;
				m_dy = ndy;
			end
		end
		if (l && !r)
			m_px = (m_px < PADDLE_STEP) ? 0 : m_px - PADDLE_STEP;
		else if (r && !l)
			m_px = (m_px + PADDLE_STEP > SCREEN_W - PADDLE_W) ? SCREEN_W - PADDLE_W :
				m_px + PADDLE_STEP;
		for (int i = 0; i < N_BRICKS; i++) begin
			bx = BRICK_X0 + (i % BRICK_COLS) * BRICK_W;
			by = BRICK_Y0 + (i / BRICK_COLS) * BRICK_H;
			if (m_health[i] != 0 && m_x + BALL_SIZE - 1 >= bx && m_x <= bx + BRICK_W - 1 &&
					m_y + BALL_SIZE - 1 >= by && m_y <= by + BRICK_H - 1) begin
				if (!m_hit)
					m_hit_idx = i;   // Lowest index is the one redrawn
				m_hit = 1'b1;
				m_health[i] = m_health[i] - 1;
			end
		end
		if (m_hit)
			m_dy = !m_dy;
		m_win = (model_alive() == '0);
	endtask

	task automatic push_rect(input int x0, input int y0, input int w, input int h,
			input colour_t c);
		for (int yy = 0; yy < h; yy++)
			for (int xx = 0; xx < w; xx++)
				exp_q.push_back({8'(x0 + xx), 8'(y0 + yy), c});
	endtask

	task automatic build_expected_pixels();
		colour_t bc;
		exp_q.delete();
		push_rect(old_x, old_y, BALL_SIZE, BALL_SIZE, BLACK);
		if (m_hit) begin
			if (m_health[m_hit_idx] == 0)
				bc = BLACK;
			else if (m_health[m_hit_idx] == 1)
				bc = BRICK_COLOUR1;
			else
				bc = BRICK_COLOUR2;
			push_rect(BRICK_X0 + (m_hit_idx % BRICK_COLS) * BRICK_W,
				BRICK_Y0 + (m_hit_idx / BRICK_COLS) * BRICK_H, BRICK_W, BRICK_H, bc);
		end
		push_rect(m_x, m_y, BALL_SIZE, BALL_SIZE, BALL_COLOUR);
		push_rect(m_px, PADDLE_Y, PADDLE_W, 1, PADDLE_COLOUR);
	endtask

	task automatic apply_reset(input logic lv);
		@(posedge clk);
		resetn <= 1'b0;
		level <= lv;   // Sampled by the cells during reset
		start <= 1'b0;
		left <= 1'b0;
		right <= 1'b0;
		repeat (10) @(posedge clk);
		resetn <= 1'b1;
		model_reset(lv);
	endtask

	// Game waits for start, nothing moves or plots
	task automatic check_idle();
		repeat (16) begin
			@(negedge clk);
			expect_equal("plot_en", int'(plot_en), 0);
			expect_equal("frame_done", int'(frame_done), 0);
			expect_equal("win", int'(win), 0);
			expect_equal("loss", int'(loss), 0);
			expect_equal("brick_alive", int'(brick_alive), int'(model_alive()));
			expect_equal("ball_x", int'(ball_x), BALL_X0);
			expect_equal("ball_y", int'(ball_y), BALL_Y0);
		end
	endtask

	task automatic start_game();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic run_frame(input logic l, input logic r);
		@(posedge clk);
		left <= l;
		right <= r;
		model_step(l, r);
		build_expected_pixels();
		got_q.delete();
		do begin
			@(negedge clk);
			if (plot_en)
				got_q.push_back({plot_x, plot_y, plot_colour});
		end while (!frame_done);
		expect_equal("plot pixel count", got_q.size(), exp_q.size());
		foreach (exp_q[i]) begin
			expect_equal("plot_x", int'(got_q[i][18:11]), int'(exp_q[i][18:11]));
			expect_equal("plot_y", int'(got_q[i][10:3]), int'(exp_q[i][10:3]));
			expect_equal("plot_colour", int'(got_q[i][2:0]), int'(exp_q[i][2:0]));
		end
		expect_equal("ball_x", int'(ball_x), m_x);
		expect_equal("ball_y", int'(ball_y), m_y);
		expect_equal("brick_alive", int'(brick_alive), int'(model_alive()));
		expect_equal("win", int'(win), int'(m_win));
		expect_equal("loss", int'(loss), int'(m_loss));
	endtask

	// Ticks stop and the flag holds
	task automatic check_game_over();
		repeat (2 * FRAME_CYCLES) begin
			@(negedge clk);
			assert (!frame_done && !plot_en) else begin
				$display("Frame activity after the game ended at time %0t", $time);
				stop_on_failure();
			end
			expect_equal("win", int'(win), int'(m_win));
			expect_equal("loss", int'(loss), int'(m_loss));
		end
	endtask

	initial begin
		logic over;
		logic cur_level;
		logic l;
		logic r;
		resetn = 1'b0;
		start = 1'b0;
		left = 1'b0;
		right = 1'b0;
		level = 1'b0;
		over = 1'b1;   // First row always starts from reset
		cur_level = 1'b0;
		foreach (rows[k]) begin
			if (over || rows[k].level != cur_level) begin
				apply_reset(rows[k].level);
				check_idle();
				start_game();
				cur_level = rows[k].level;
				over = 1'b0;
			end
			for (int f = 0; f < int'(rows[k].frames) && !over; f++) begin
				if (rows[k].rnd) begin
					rng_state = xorshift32(rng_state);
					l = rng_state[0];
					r = rng_state[1];
				end else begin
					l = rows[k].left;
					r = rows[k].right;
				end
				run_frame(l, r);
				over = m_win || m_loss;
			end
			if (over)
				check_game_over();
			if (rows[k].ends == 2'd1) begin
				assert (m_win) else begin
					$display("Row %0d ended without reaching win", k);
					stop_on_failure();
				end
			end else if (rows[k].ends == 2'd2) begin
				assert (m_loss) else begin
					$display("Row %0d ended without reaching loss", k);
					stop_on_failure();
				end
			end
		end
		$display("All checks passed");
		$finish;
	end

	// Every row may add reset, the first tick and the game-over wait
	initial begin
		time limit;
		limit = (total_frames() + 4 * $size(rows) + 20) * FRAME_CYCLES * 100;
		#(limit);
		$display("Timeout, the DUT stopped producing frames");
		$display("Checks failed");
		$fatal(1);
	end

endmodule

/* testbench/brickbreaker_props.sv */
`timescale 1ns/1ns

module brickbreaker_props (
	input logic             clk,
	input logic             resetn,
	input logic             plot_en,
	input game_pkg::coord_t plot_x,
	input game_pkg::coord_t plot_y,
	input logic             frame_done,
	input logic             win,
	input logic             loss
);
	import game_pkg::*;

	// Every plotted pixel lands on the frame
	plot_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		plot_en |-> (int'(plot_x) < SCREEN_W && int'(plot_y) < SCREEN_H))
		else $error("Plot pixel outside the screen");

	done_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
		frame_done |=> !frame_done)
		else $error("frame_done high for two cycles in a row");

	flags_exclusive: assert property (@(posedge clk) disable iff (!resetn)
		!(win && loss))
		else $error("win and loss set together");

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	always #50 clk = ~clk;   // 100 ns period

endmodule

/* source/brickbreaker.sv */
`timescale 1ns/1ns

module brickbreaker (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          start,
	input  logic                          left,
	input  logic                          right,
	input  logic                          level,
	output game_pkg::coord_t              plot_x,
	output game_pkg::coord_t              plot_y,
	output draw_pkg::colour_t             plot_colour,
	output logic                          plot_en,
	output logic                          frame_done,
	output game_pkg::coord_t              ball_x,
	output game_pkg::coord_t              ball_y,
	output logic [game_pkg::N_BRICKS-1:0] brick_alive,
	output logic                          win,
	output logic                          loss
);
	import game_pkg::*;
	import draw_pkg::*;

	logic move_go;
	logic collide_go;
	logic resolve_go;
	logic probe;
	logic bounce_y;
	logic any_hit;
	logic rect_start;
	logic rect_done;
	plot_layer_t plot_layer;
	coord_t paddle_x;
	logic [N_BRICKS-1:0] hit;
	health_t health [N_BRICKS];
	logic [BRICK_IDX_W-1:0] hit_index;
	health_t hit_health;

	frame_sequencer u_seq (
		.clk(clk), .resetn(resetn), .start(start),
		.any_hit(any_hit), .win(win), .loss(loss), .rect_done(rect_done),
		.move_go(move_go), .collide_go(collide_go), .resolve_go(resolve_go),
		.plot_layer(plot_layer), .rect_start(rect_start), .frame_done(frame_done)
	);

	ball_motion u_ball (
		.clk(clk), .resetn(resetn),
		.move_go(move_go), .collide_go(collide_go), .resolve_go(resolve_go),
		.bounce_y(bounce_y), .paddle_x(paddle_x),
		.ball_x(ball_x), .ball_y(ball_y), .probe(probe), .loss(loss)
	);

	paddle u_paddle (
		.clk(clk), .resetn(resetn), .left(left), .right(right),
		.move_go(move_go), .paddle_x(paddle_x)
	);

	// Each cell sees the ball shifted into its own corner
	for (genvar i = 0; i < N_BRICKS; i++) begin : g_brick
		localparam coord_t CELL_X = coord_t'(BRICK_X0 + (i % BRICK_COLS) * BRICK_W);
		localparam coord_t CELL_Y = coord_t'(BRICK_Y0 + (i / BRICK_COLS) * BRICK_H);
		coord_t rel_x;
		coord_t rel_y;
		health_t init_health;

		assign rel_x = ball_x - CELL_X;
		assign rel_y = ball_y - CELL_Y;
		assign init_health = level ? LEVEL1_HEALTH[i] : LEVEL0_HEALTH[i];

		brick_cell u_cell (
			.clk(clk), .resetn(resetn), .init_health(init_health),
			.ball_x(rel_x), .ball_y(rel_y), .probe(probe),
			.hit(hit[i]), .health(health[i])
		);

		assign brick_alive[i] = (health[i] != '0);
	end

	hit_resolver u_resolve (
		.clk(clk), .resetn(resetn), .hit(hit), .health(health),
		.bounce_y(bounce_y), .any_hit(any_hit),
		.hit_index(hit_index), .hit_health(hit_health), .win(win)
	);

	plot_engine u_plot (
		.clk(clk), .resetn(resetn), .rect_start(rect_start), .plot_layer(plot_layer),
		.ball_x(ball_x), .ball_y(ball_y), .paddle_x(paddle_x),
		.hit_index(hit_index), .hit_health(hit_health),
		.plot_x(plot_x), .plot_y(plot_y), .plot_colour(plot_colour),
		.plot_en(plot_en), .rect_done(rect_done)
	);

endmodule

/* source/plot_engine.sv */
`timescale 1ns/1ns

module plot_engine (
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             rect_start,
	input  draw_pkg::plot_layer_t            plot_layer,
	input  game_pkg::coord_t                 ball_x,
	input  game_pkg::coord_t                 ball_y,
	input  game_pkg::coord_t                 paddle_x,
	input  logic [game_pkg::BRICK_IDX_W-1:0] hit_index,
	input  game_pkg::health_t                hit_health,
	output game_pkg::coord_t                 plot_x,
	output game_pkg::coord_t                 plot_y,
	output draw_pkg::colour_t                plot_colour,
	output logic                             plot_en,
	output logic                             rect_done
);
	import game_pkg::*;
	import draw_pkg::*;

	plot_layer_t layer;   // Latched at start
	logic active;
	logic [3:0] cx;
	logic [1:0] cy;
	logic [3:0] w_last;
	logic [1:0] h_last;
	coord_t org_x;
	coord_t org_y;
	logic last_pixel;

	always_comb begin
		org_x = ball_x;
		org_y = ball_y;
		w_last = 4'(BALL_SIZE - 1);
		h_last = 2'(BALL_SIZE - 1);
		plot_colour = BALL_COLOUR;
		case (layer)
			L_ERASE: plot_colour = BLACK;   // Ball not moved yet
			L_BRICK: begin
				org_x = coord_t'(BRICK_X0 + (hit_index % BRICK_COLS) * BRICK_W);
				org_y = coord_t'(BRICK_Y0 + (hit_index / BRICK_COLS) * BRICK_H);
				w_last = 4'(BRICK_W - 1);
				h_last = 2'(BRICK_H - 1);
				if (hit_health == 2'd0)
					plot_colour = BLACK;
				else if (hit_health == 2'd1)
					plot_colour = BRICK_COLOUR1;
				else
					plot_colour = BRICK_COLOUR2;
			end
			L_PADDLE: begin
				org_x = paddle_x;
				org_y = coord_t'(PADDLE_Y);
				w_last = 4'(PADDLE_W - 1);
				h_last = 2'd0;
				plot_colour = PADDLE_COLOUR;
			end
			default: plot_colour = BALL_COLOUR;
		endcase
	end

	assign last_pixel = (cx == w_last) && (cy == h_last);

	// Row-major walk, a new start overrides the end of the old one
	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			layer <= L_BALL;
			cx <= '0;
			cy <= '0;
		end else if (rect_start) begin
			active <= 1'b1;
			layer <= plot_layer;
			cx <= '0;
			cy <= '0;
		end else if (active) begin
			if (cx == w_last) begin
				cx <= '0;
				cy <= cy + 2'd1;
				if (cy == h_last)
					active <= 1'b0;
			end else begin
				cx <= cx + 4'd1;
			end
		end
	end

	assign plot_x = org_x + {4'b0, cx};
	assign plot_y = org_y + {6'b0, cy};
	assign plot_en = active;
	assign rect_done = active && last_pixel;

endmodule

/* source/paddle.sv */
`timescale 1ns/1ns

module paddle (
	input  logic             clk,
	input  logic             resetn,
	input  logic             left,
	input  logic             right,
	input  logic             move_go,
	output game_pkg::coord_t paddle_x
);
	import game_pkg::*;

	logic go_left;
	logic go_right;

	// Both held cancel out
	assign go_left = left && !right;
	assign go_right = right && !left;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			paddle_x <= coord_t'(PADDLE_START);
		end else if (move_go) begin
			if (go_left)
				paddle_x <= (paddle_x < coord_t'(PADDLE_STEP)) ? '0 :
					paddle_x - coord_t'(PADDLE_STEP);
			else if (go_right)
				paddle_x <= (paddle_x > coord_t'(PADDLE_X_MAX - PADDLE_STEP)) ?
					coord_t'(PADDLE_X_MAX) : paddle_x + coord_t'(PADDLE_STEP);
		end
	end

endmodule

/* source/hit_resolver.sv */
`timescale 1ns/1ns

module hit_resolver (
	input  logic                                 clk,
	input  logic                                 resetn,
	input  logic [game_pkg::N_BRICKS-1:0]        hit,
	input  game_pkg::health_t                    health [game_pkg::N_BRICKS],
	output logic                                 bounce_y,
	output logic                                 any_hit,
	output logic [game_pkg::BRICK_IDX_W-1:0]     hit_index,
	output game_pkg::health_t                    hit_health,
	output logic                                 win
);
	import game_pkg::*;

	logic [BRICK_IDX_W-1:0] first_hit;
	logic all_clear;

	// Lowest index wins, scanning down so it overwrites last
	always_comb begin
		first_hit = '0;
		for (int i = N_BRICKS - 1; i >= 0; i--) begin
			if (hit[i])
				first_hit = BRICK_IDX_W'(i);
		end
	end

	always_comb begin
		all_clear = 1'b1;
		for (int i = 0; i < N_BRICKS; i++) begin
			if (health[i] != '0)
				all_clear = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			any_hit <= 1'b0;
			win <= 1'b0;
		end else begin
			any_hit <= |hit;              // High during RESOLVE only
			win <= win | all_clear;
		end
	end

	// Cell still shows the old health while hit is up
	always_ff @(posedge clk) begin
		if (|hit) begin
			hit_index <= first_hit;
			hit_health <= health[first_hit] - 2'd1;
		end
	end

	assign bounce_y = any_hit;

endmodule

/* source/brick_cell.sv */
`timescale 1ns/1ns

// Ball coordinates arrive relative to this brick's top-left corner
module brick_cell (
	input  logic              clk,
	input  logic              resetn,
	input  game_pkg::health_t init_health,
	input  game_pkg::coord_t  ball_x,
	input  game_pkg::coord_t  ball_y,
	input  logic              probe,
	output logic              hit,
	output game_pkg::health_t health
);
	import game_pkg::*;

	coord_t span_x;
	coord_t span_y;
	logic overlap;
	logic alive;

	// Shift so any touching position lands in a small unsigned window,
	// a ball left of or above the brick wraps far out of it
	assign span_x = ball_x + coord_t'(BALL_SIZE - 1);
	assign span_y = ball_y + coord_t'(BALL_SIZE - 1);

	assign overlap = (span_x < coord_t'(BRICK_W + BALL_SIZE - 1)) &&
		(span_y < coord_t'(BRICK_H + BALL_SIZE - 1));

	assign alive = (health != '0);
	assign hit = probe && overlap && alive;

	always_ff @(posedge clk) begin
		if (!resetn)
			health <= init_health;   // Level table picked at reset
		else if (hit)
			health <= health - 2'd1;
	end

endmodule

/* source/ball_motion.sv */
`timescale 1ns/1ns

module ball_motion (
	input  logic             clk,
	input  logic             resetn,
	input  logic             move_go,
	input  logic             collide_go,
	input  logic             resolve_go,
	input  logic             bounce_y,
	input  game_pkg::coord_t paddle_x,
	output game_pkg::coord_t ball_x,
	output game_pkg::coord_t ball_y,
	output logic             probe,
	output logic             loss
);
	import game_pkg::*;

	logic dx_pos;    // 1 moves right
	logic dy_down;   // 1 moves down
	logic next_dx;
	logic next_dy;
	logic on_paddle;
	logic falls;
	coord_t next_x;
	coord_t next_y;

	// Bottom row lands on the paddle row next step, spans overlap
	assign on_paddle = (ball_y == coord_t'(PADDLE_Y - BALL_SIZE)) &&
		(ball_x + BALL_SIZE - 1 >= paddle_x) &&
		(ball_x <= paddle_x + PADDLE_W - 1);

	// Walls and paddle flip first, then the step uses the new direction
	always_comb begin
		next_dx = dx_pos;
		if (dx_pos && ball_x == coord_t'(BALL_X_MAX))
			next_dx = 1'b0;
		else if (!dx_pos && ball_x == '0)
			next_dx = 1'b1;

		next_dy = dy_down;
		if (!dy_down && ball_y == '0)
			next_dy = 1'b1;
		else if (dy_down && on_paddle)
			next_dy = 1'b0;

		next_x = next_dx ? ball_x + 8'd1 : ball_x - 8'd1;
		next_y = next_dy ? ball_y + 8'd1 : ball_y - 8'd1;
		falls = next_dy && (ball_y >= coord_t'(BALL_Y_MAX));
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ball_x <= coord_t'(BALL_X0);
			ball_y <= coord_t'(BALL_Y0);
			dx_pos <= 1'b1;
			dy_down <= 1'b0;
			loss <= 1'b0;
		end else if (move_go && !loss) begin
			if (falls) begin
				loss <= 1'b1;   // Ball stays put below the last legal row
			end else begin
				ball_x <= next_x;
				ball_y <= next_y;
				dx_pos <= next_dx;
				dy_down <= next_dy;
			end
		end else if (resolve_go && bounce_y) begin
			dy_down <= ~dy_down;
		end
	end

	assign probe = collide_go;   // Broadcast to every cell

endmodule

/* source/frame_sequencer.sv */
`timescale 1ns/1ns

module frame_sequencer (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   start,
	input  logic                   any_hit,
	input  logic                   win,
	input  logic                   loss,
	input  logic                   rect_done,
	output logic                   move_go,
	output logic                   collide_go,
	output logic                   resolve_go,
	output draw_pkg::plot_layer_t  plot_layer,
	output logic                   rect_start,
	output logic                   frame_done
);
	import game_pkg::*;
	import draw_pkg::*;

	frame_state_t state;
	frame_state_t next_state;
	logic armed;
	logic [FRAME_CNT_W-1:0] tick_cnt;
	logic tick;

	// Game clock runs free once start has been seen
	always_ff @(posedge clk) begin
		if (!resetn) begin
			armed <= 1'b0;
			tick_cnt <= '0;
		end else begin
			if (start)
				armed <= 1'b1;
			if (armed && state != OVER)
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign tick = armed && (tick_cnt == FRAME_CNT_W'(FRAME_CYCLES - 1));

	// Plot phases start the next rectangle on the cycle they hand over
	always_comb begin
		next_state = state;
		rect_start = 1'b0;
		plot_layer = L_ERASE;
		case (state)
			WAIT: begin
				if (tick) begin
					next_state = ERASE;
					rect_start = 1'b1;
				end
			end
			ERASE: if (rect_done) next_state = MOVE;
			MOVE: next_state = COLLIDE;
			COLLIDE: next_state = RESOLVE;   // Cells test the moved ball here
			RESOLVE: begin
				rect_start = 1'b1;
				if (any_hit) begin
					next_state = BRICK;
					plot_layer = L_BRICK;
				end else begin
					next_state = BALL;
					plot_layer = L_BALL;
				end
			end
			BRICK: begin
				plot_layer = L_BALL;
				if (rect_done) begin
					next_state = BALL;
					rect_start = 1'b1;
				end
			end
			BALL: begin
				plot_layer = L_PADDLE;
				if (rect_done) begin
					next_state = PADDLE;
					rect_start = 1'b1;
				end
			end
			PADDLE: if (rect_done) next_state = DONE;
			DONE: next_state = (win || loss) ? OVER : WAIT;
			OVER: next_state = OVER;   // Held until reset
			default: next_state = WAIT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= WAIT;
		else
			state <= next_state;
	end

	assign move_go = (state == MOVE);
	assign collide_go = (state == COLLIDE);
	assign resolve_go = (state == RESOLVE);
	assign frame_done = (state == DONE);

endmodule

/* source/draw_pkg.sv */
package draw_pkg;

	// Phases of one game step
	typedef enum logic [3:0] {
		WAIT,
		ERASE,
		MOVE,
		COLLIDE,
		RESOLVE,
		BRICK,
		BALL,
		PADDLE,
		DONE,
		OVER
	} frame_state_t;

	// Which rectangle the plot engine walks
	typedef enum logic [1:0] {L_BALL, L_BRICK, L_PADDLE, L_ERASE} plot_layer_t;

	typedef logic [2:0] colour_t;

	localparam colour_t BLACK = 3'd0;
	localparam colour_t BALL_COLOUR = 3'd7;
	localparam colour_t PADDLE_COLOUR = 3'd2;
	localparam colour_t BRICK_COLOUR1 = 3'd4;   // One hit left
	localparam colour_t BRICK_COLOUR2 = 3'd6;

endpackage

/* source/game_pkg.sv */
package game_pkg;

	typedef logic [1:0] health_t;   // Hits left on one brick
	typedef logic [7:0] coord_t;    // Pixel coordinate on either axis

	// Frame
	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;

	// Ball
	localparam int BALL_SIZE = 2;
	localparam int BALL_X0 = 80;
	localparam int BALL_Y0 = 100;
	localparam int BALL_X_MAX = SCREEN_W - BALL_SIZE;   // Last legal top-left x
	localparam int BALL_Y_MAX = SCREEN_H - BALL_SIZE;

	// Paddle
	localparam int PADDLE_W = 16;
	localparam int PADDLE_Y = 112;
	localparam int PADDLE_START = 72;
	localparam int PADDLE_STEP = 2;
	localparam int PADDLE_X_MAX = SCREEN_W - PADDLE_W;

	// Brick grid, packed edge to edge
	localparam int BRICK_W = 16;
	localparam int BRICK_H = 4;
	localparam int BRICK_COLS = 8;
	localparam int BRICK_ROWS = 2;
	localparam int N_BRICKS = BRICK_COLS * BRICK_ROWS;
	localparam int BRICK_IDX_W = $clog2(N_BRICKS);
	localparam int BRICK_X0 = 16;
	localparam int BRICK_Y0 = 16;

	// Level 0 is the full wall, tougher top row
	localparam health_t LEVEL0_HEALTH [N_BRICKS] = '{
		2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2,
		2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1, 2'd1
	};
	localparam health_t LEVEL1_HEALTH [N_BRICKS] = '{3: 2'd1, default: 2'd0};

	// Frame tick spacing in clocks
	localparam int FRAME_CYCLES = 256;
	localparam int FRAME_CNT_W = $clog2(FRAME_CYCLES);

endpackage
